// File: hw/wb2sdr_consts.svh
`ifndef WB2SDR_CONSTS_SVH
`define WB2SDR_CONSTS_SVH

// --------------------
// Bus widths
// --------------------

// Wishbone and SDRAM data width
`define WB2SDR_DATA_W 32

// Byte lanes per data word
`define WB2SDR_SEL_W (`WB2SDR_DATA_W / 8)

// Word address toward the controller
`define WB2SDR_ADDR_W 25

// --------------------
// Queue depths
// --------------------

// Commands waiting for controller acknowledge
`define WB2SDR_CMD_DEPTH 4
// Write beats waiting for wr_next
`define WB2SDR_WR_DEPTH 8
// Read beats on the way back to Wishbone
`define WB2SDR_RD_DEPTH 4

`endif

// File: hw/wb2sdr_pkg.sv
`default_nettype none

`include "wb2sdr_consts.svh"

package wb2sdr_pkg;

  // --------------------
  // Controller side
  // --------------------

  // One queued request
  // Read flag doubles as active low write strobe
  typedef struct packed {
    logic                       wr_n;
    logic [`WB2SDR_ADDR_W-1:0]  addr;
  } sdr_cmd_t;

  // One write beat with active low byte enables
  typedef struct packed {
    logic [`WB2SDR_SEL_W-1:0]   en_n;
    logic [`WB2SDR_DATA_W-1:0]  data;
  } sdr_wr_beat_t;

  // One returned read word
  typedef struct packed {
    logic [`WB2SDR_DATA_W-1:0]  data;
  } sdr_rd_beat_t;

  // --------------------
  // Wishbone side
  // --------------------

  // Cycle qualifiers from the master
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
  } wb_req_t;

endpackage

`default_nettype wire

// File: hw/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     sdram_clk,
  input  logic     wb_clk_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     full_o,
  output logic     empty_o
);

  // Pointer and count widths
  // Count needs one extra state for full
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // --------------------
  // Storage and state
  // --------------------

  payload_t             mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;

  // Last slot index for pointer wrap
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Write side advance
      if (push_i) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      // Read side advance
      if (pop_i) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy
      // Simultaneous push and pop leaves it unchanged
      case ({push_i, pop_i})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------
  // Data path
  // --------------------

  // Payload written at the write pointer
  always_ff @(posedge sdram_clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // First word falls through
  // Head valid one edge after the push
  assign head_o = mem[rd_ptr];

  // Flags from the registered count
  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);

endmodule

`default_nettype wire

// File: hw/wb_req_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module wb_req_ctrl (
  input  logic                sdram_clk,
  input  logic                wb_clk_i,
  input  wb2sdr_pkg::wb_req_t wb_req_i,
  input  logic                cmd_full_i,
  input  logic                wr_full_i,
  input  logic                rd_empty_i,
  output logic                wb_ack_o,
  output logic                cmd_push_o,
  output logic                wr_push_o,
  output logic                rd_pop_o
);

  // Idle or one read in flight
  typedef enum logic {
    ST_IDLE    = 1'b0,
    ST_RD_PEND = 1'b1
  } state_t;

  state_t state_q;
  state_t state_d;

  // --------------------
  // Request decode
  // --------------------

  logic bus_req;
  logic wr_req;
  logic rd_req;
  logic wr_room;
  logic rd_issue;

  // Valid cycle from the master
  assign bus_req = wb_req_i.cyc & wb_req_i.stb;
  assign wr_req  = bus_req & wb_req_i.we;
  assign rd_req  = bus_req & ~wb_req_i.we;

  // Write needs a command slot and a data slot
  assign wr_room = ~cmd_full_i & ~wr_full_i;

  // Read command only once per access
  // Held off while a read is outstanding
  assign rd_issue = rd_req & ~cmd_full_i & (state_q == ST_IDLE);

  // --------------------
  // Acknowledge
  // --------------------

  // Writes acked on entry into the queues
  // Reads acked once the data is back
  always_comb begin
    if (wr_req) begin
      wb_ack_o = wr_room;
    end else if (rd_req) begin
      wb_ack_o = ~rd_empty_i;
    end else begin
      wb_ack_o = 1'b0;
    end
  end

  // --------------------
  // Queue strobes
  // --------------------

  // Command push for an acked write or a fresh read
  assign cmd_push_o = (wr_req & wr_room) | rd_issue;

  // Write beat goes in with its command
  assign wr_push_o = wr_req & wr_room;

  // Head read beat consumed by the ack
  assign rd_pop_o = rd_req & ~rd_empty_i;

  // --------------------
  // Pending read FSM
  // --------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // Read accepted into the command queue
        if (rd_issue) begin
          state_d = ST_RD_PEND;
        end
      end
      ST_RD_PEND: begin
        // Data handed to the master
        if (rd_pop_o) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/wb2sdr_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb2sdr_consts.svh"

module wb2sdr_top (
  // Clock and reset
  input  logic                       sdram_clk,
  input  logic                       wb_clk_i,
  // Wishbone slave
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`WB2SDR_ADDR_W-1:0]  wb_addr_i,
  input  logic [`WB2SDR_DATA_W-1:0]  wb_dat_i,
  input  logic [`WB2SDR_SEL_W-1:0]   wb_sel_i,
  output logic                       wb_ack_o,
  output logic [`WB2SDR_DATA_W-1:0]  wb_dat_o,
  // Controller request
  output logic                       sdr_req_o,
  output logic [`WB2SDR_ADDR_W-1:0]  sdr_req_addr_o,
  output logic                       sdr_req_wr_n_o,
  input  logic                       sdr_req_ack_i,
  // Controller data
  output logic [`WB2SDR_DATA_W-1:0]  sdr_wr_data_o,
  output logic [`WB2SDR_SEL_W-1:0]   sdr_wr_en_n_o,
  input  logic                       sdr_wr_next_i,
  input  logic                       sdr_rd_valid_i,
  input  logic [`WB2SDR_DATA_W-1:0]  sdr_rd_data_i
);

  // --------------------
  // Internal signals
  // --------------------

  wb2sdr_pkg::wb_req_t       wb_req;

  wb2sdr_pkg::sdr_cmd_t      cmd_in;
  wb2sdr_pkg::sdr_cmd_t      cmd_head;
  wb2sdr_pkg::sdr_wr_beat_t  wr_in;
  wb2sdr_pkg::sdr_wr_beat_t  wr_head;
  wb2sdr_pkg::sdr_rd_beat_t  rd_in;
  wb2sdr_pkg::sdr_rd_beat_t  rd_head;

  logic cmd_push;
  logic cmd_full;
  logic cmd_empty;
  logic wr_push;
  logic wr_full;
  logic rd_pop;
  logic rd_empty;

  // --------------------
  // Struct packing
  // --------------------

  // Master qualifiers
  assign wb_req = '{cyc: wb_cyc_i, stb: wb_stb_i, we: wb_we_i};

  // Read flag is the inverted write enable
  assign cmd_in = '{wr_n: ~wb_we_i, addr: wb_addr_i};

  // Byte selects become active low enables
  assign wr_in = '{en_n: ~wb_sel_i, data: wb_dat_i};

  assign rd_in = '{data: sdr_rd_data_i};

  // Controller sees the queue heads
  assign sdr_req_o      = ~cmd_empty;
  assign sdr_req_addr_o = cmd_head.addr;
  assign sdr_req_wr_n_o = cmd_head.wr_n;
  assign sdr_wr_data_o  = wr_head.data;
  assign sdr_wr_en_n_o  = wr_head.en_n;

  // Read word straight from the head
  assign wb_dat_o = rd_head.data;

  // --------------------
  // Wishbone control
  // --------------------

  wb_req_ctrl u_ctrl (
    .sdram_clk  (sdram_clk),
    .wb_clk_i   (wb_clk_i),
    .wb_req_i   (wb_req),
    .cmd_full_i (cmd_full),
    .wr_full_i  (wr_full),
    .rd_empty_i (rd_empty),
    .wb_ack_o   (wb_ack_o),
    .cmd_push_o (cmd_push),
    .wr_push_o  (wr_push),
    .rd_pop_o   (rd_pop)
  );

  // --------------------
  // Queues
  // --------------------

  // Commands popped by the controller acknowledge
  sync_fifo #(
    .payload_t (wb2sdr_pkg::sdr_cmd_t),
    .DEPTH     (`WB2SDR_CMD_DEPTH)
  ) u_cmd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (cmd_push),
    .push_data_i (cmd_in),
    .pop_i       (sdr_req_ack_i),
    .head_o      (cmd_head),
    .full_o      (cmd_full),
    .empty_o     (cmd_empty)
  );

  // Write beats popped by wr_next
  sync_fifo #(
    .payload_t (wb2sdr_pkg::sdr_wr_beat_t),
    .DEPTH     (`WB2SDR_WR_DEPTH)
  ) u_wr_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (wr_push),
    .push_data_i (wr_in),
    .pop_i       (sdr_wr_next_i),
    .head_o      (wr_head),
    .full_o      (wr_full),
    .empty_o     ()
  );

  // Read beats pushed by rd_valid
  sync_fifo #(
    .payload_t (wb2sdr_pkg::sdr_rd_beat_t),
    .DEPTH     (`WB2SDR_RD_DEPTH)
  ) u_rd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (rd_in),
    .pop_i       (rd_pop),
    .head_o      (rd_head),
    .full_o      (),
    .empty_o     (rd_empty)
  );

endmodule

`default_nettype wire

// File: tests/wb2sdr_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module wb2sdr_assertions (
  input logic sdram_clk,
  input logic wb_clk_i,
  input logic push_i,
  input logic pop_i,
  input logic full_i,
  input logic empty_i
);

  // Overflow
  // A push would overwrite the head
  a_no_push_full: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    full_i |-> !push_i)
    else $error("push into a full FIFO");

  // Underflow
  a_no_pop_empty: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    empty_i |-> !pop_i)
    else $error("pop from an empty FIFO");

  // Queue cleared by reset
  a_reset_empty: assert property (@(posedge sdram_clk)
    wb_clk_i |=> empty_i)
    else $error("FIFO not empty after reset");

endmodule

bind sync_fifo wb2sdr_assertions u_fifo_chk (
  .sdram_clk (sdram_clk),
  .wb_clk_i  (wb_clk_i),
  .push_i    (push_i),
  .pop_i     (pop_i),
  .full_i    (full_o),
  .empty_i   (empty_o)
);

`default_nettype wire

// File: tests/tb_wb2sdr.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb2sdr_consts.svh"

module tb_wb2sdr;

  localparam int NUM_STIM    = 16;
  localparam int CYCLE_LIMIT = 64 * NUM_STIM + 100;
  localparam int MEM_WORDS   = 64;

  // One Wishbone access
  // Hold keeps the controller ack off
  typedef struct packed {
    logic                      we;
    logic                      hold;
    logic [`WB2SDR_ADDR_W-1:0] addr;
    logic [`WB2SDR_DATA_W-1:0] data;
    logic [`WB2SDR_SEL_W-1:0]  sel;
  } stim_t;

  // What the controller should see for one command
  typedef struct packed {
    wb2sdr_pkg::sdr_cmd_t     cmd;
    wb2sdr_pkg::sdr_wr_beat_t beat;
  } exp_req_t;

  logic                      sdram_clk;
  logic                      wb_clk_i;
  logic                      wb_cyc_i;
  logic                      wb_stb_i;
  logic                      wb_we_i;
  logic [`WB2SDR_ADDR_W-1:0] wb_addr_i;
  logic [`WB2SDR_DATA_W-1:0] wb_dat_i;
  logic [`WB2SDR_SEL_W-1:0]  wb_sel_i;
  logic                      wb_ack_o;
  logic [`WB2SDR_DATA_W-1:0] wb_dat_o;
  logic                      sdr_req_o;
  logic [`WB2SDR_ADDR_W-1:0] sdr_req_addr_o;
  logic                      sdr_req_wr_n_o;
  logic                      sdr_req_ack_i;
  logic [`WB2SDR_DATA_W-1:0] sdr_wr_data_o;
  logic [`WB2SDR_SEL_W-1:0]  sdr_wr_en_n_o;
  logic                      sdr_wr_next_i;
  logic                      sdr_rd_valid_i;
  logic [`WB2SDR_DATA_W-1:0] sdr_rd_data_i;

  stim_t                     stim [NUM_STIM];
  exp_req_t                  exp_q [$];
  logic [`WB2SDR_DATA_W-1:0] exp_mem [MEM_WORDS];
  logic [`WB2SDR_DATA_W-1:0] model_mem [MEM_WORDS];
  logic                      hold_ack;
  int                        held_writes;
  logic [15:0]               lfsr_state = 16'd29724;

  wb2sdr_top UUT (.*);

  // --------------------
  // Helpers
  // --------------------

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s (got 0x%08h, expected 0x%08h)",
               $time, what, got, exp);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Fibonacci LFSR
  // Taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output int val);
    int k;
    val = 0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  // Power-up contents
  // Unique per word
  function automatic logic [31:0] fill_word(input int idx);
    return {8'(idx), 8'(idx ^ 8'h5A), 8'(~idx), 8'(idx * 3)};
  endfunction

  task automatic load_table();
    // we, hold, addr, data, sel
    stim[0]  = '{1'b1, 1'b0, 25'h000_0005, 32'h1122_3344, 4'hF};
    stim[1]  = '{1'b1, 1'b0, 25'h001_0009, 32'hA5A5_5A5A, 4'b0101};
    stim[2]  = '{1'b0, 1'b0, 25'h000_0005, 32'h0, 4'hF};
    stim[3]  = '{1'b0, 1'b0, 25'h001_0009, 32'h0, 4'hF};
    // Write then read straight after
    // Both on the same word
    stim[4]  = '{1'b1, 1'b0, 25'h000_000C, 32'hCAFE_F00D, 4'b1100};
    stim[5]  = '{1'b0, 1'b0, 25'h000_000C, 32'h0, 4'hF};
    stim[6]  = '{1'b1, 1'b0, 25'h1F0_0011, 32'h0BAD_BEEF, 4'b0011};
    stim[7]  = '{1'b0, 1'b0, 25'h1F0_0011, 32'h0, 4'hF};
    // Ack withheld
    // Fifth write meets a full command queue
    stim[8]  = '{1'b1, 1'b1, 25'h000_0020, 32'h0101_0101, 4'hF};
    stim[9]  = '{1'b1, 1'b1, 25'h000_0021, 32'h0202_0202, 4'hF};
    stim[10] = '{1'b1, 1'b1, 25'h000_0022, 32'h0303_0303, 4'b1000};
    stim[11] = '{1'b1, 1'b1, 25'h000_0021, 32'h0404_0404, 4'b0110};
    stim[12] = '{1'b1, 1'b1, 25'h000_0023, 32'h0505_0505, 4'hF};
    stim[13] = '{1'b0, 1'b0, 25'h000_0021, 32'h0, 4'hF};
    stim[14] = '{1'b0, 1'b0, 25'h000_0023, 32'h0, 4'hF};
    // Untouched word keeps its fill
    stim[15] = '{1'b0, 1'b0, 25'h000_003F, 32'h0, 4'hF};
  endtask

  // --------------------
  // Wishbone master
  // --------------------

  task automatic apply_entry(input stim_t s);
    logic [5:0] idx;
    int         b;
    idx = s.addr[5:0];
    // Hold group starts on an empty command queue
    if (s.hold && !hold_ack) begin
      @(negedge sdram_clk);
      while (sdr_req_o) @(negedge sdram_clk);
      hold_ack    = 1'b1;
      held_writes = 0;
      @(posedge sdram_clk);
      #1;
    end
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    wb_we_i   = s.we;
    wb_addr_i = s.addr;
    wb_dat_i  = s.we ? s.data : '0;
    wb_sel_i  = s.sel;
    exp_q.push_back('{cmd: '{wr_n: ~s.we, addr: s.addr}, beat: '{en_n: ~s.sel, data: s.data}});
    if (s.hold && held_writes == `WB2SDR_CMD_DEPTH) begin
      repeat (8) begin
        @(negedge sdram_clk);
        check(32'(wb_ack_o), 32'd0, "write acked into a full command queue");
      end
      // Controller resumes
      hold_ack = 1'b0;
    end
    @(negedge sdram_clk);
    while (!wb_ack_o) @(negedge sdram_clk);
    if (s.we) begin
      for (b = 0; b < `WB2SDR_SEL_W; b++) begin
        if (s.sel[b]) exp_mem[idx][8*b +: 8] = s.data[8*b +: 8];
      end
    end else begin
      check(wb_dat_o, exp_mem[idx], "read data");
    end
    if (s.hold) held_writes++;
    @(posedge sdram_clk);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // --------------------
  // Clock and run control
  // --------------------

  initial begin
    sdram_clk = 1'b0;
    forever #4 sdram_clk = ~sdram_clk;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge sdram_clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("test failed");
    $fatal(1, "timeout");
  end

  initial begin : main
    int i;
    wb_clk_i    = 1'b1;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_addr_i   = '0;
    wb_dat_i    = '0;
    wb_sel_i    = '0;
    hold_ack    = 1'b0;
    held_writes = 0;
    load_table();
    for (i = 0; i < MEM_WORDS; i++) exp_mem[i] = fill_word(i);
    repeat (10) @(posedge sdram_clk);
    #1;
    wb_clk_i = 1'b0;
    // Idle bus after reset
    @(negedge sdram_clk);
    check(32'(wb_ack_o), 32'd0, "ack after reset");
    check(32'(sdr_req_o), 32'd0, "request after reset");
    @(posedge sdram_clk);
    #1;
    for (i = 0; i < NUM_STIM; i++) apply_entry(stim[i]);
    // Let the controller drain everything
    @(negedge sdram_clk);
    while (sdr_req_o || exp_q.size() != 0) @(negedge sdram_clk);
    for (i = 0; i < MEM_WORDS; i++) begin
      check(model_mem[i], exp_mem[i], $sformatf("memory word %0d", i));
    end
    $display("test passed");
    $finish;
  end

  // --------------------
  // SDRAM controller model
  // --------------------

  initial begin : responder
    exp_req_t   exp;
    int         gap;
    int         rd_wait;
    logic       rd_busy;
    logic [5:0] rd_idx;
    int         b;
    sdr_req_ack_i  = 1'b0;
    sdr_wr_next_i  = 1'b0;
    sdr_rd_valid_i = 1'b0;
    sdr_rd_data_i  = '0;
    gap     = 0;
    rd_wait = 0;
    rd_busy = 1'b0;
    rd_idx  = '0;
    for (b = 0; b < MEM_WORDS; b++) model_mem[b] = fill_word(b);
    @(negedge wb_clk_i);
    forever begin
      @(posedge sdram_clk);
      #1;
      sdr_req_ack_i  = 1'b0;
      sdr_wr_next_i  = 1'b0;
      sdr_rd_valid_i = 1'b0;
      // Read word back after a random latency
      if (rd_busy) begin
        if (rd_wait == 0) begin
          sdr_rd_valid_i = 1'b1;
          sdr_rd_data_i  = model_mem[rd_idx];
          rd_busy        = 1'b0;
        end else begin
          rd_wait--;
        end
      end
      if (gap > 0) begin
        gap--;
      end else if (sdr_req_o && !hold_ack) begin
        sdr_req_ack_i = 1'b1;
        check(32'(exp_q.size() != 0), 32'd1, "request with nothing issued");
        exp = exp_q.pop_front();
        check(32'(sdr_req_addr_o), 32'(exp.cmd.addr), "request address");
        check(32'(sdr_req_wr_n_o), 32'(exp.cmd.wr_n), "request direction");
        if (!sdr_req_wr_n_o) begin
          // Beat of this write sits at the write queue head
          sdr_wr_next_i = 1'b1;
          check(sdr_wr_data_o, exp.beat.data, "write data");
          check(32'(sdr_wr_en_n_o), 32'(exp.beat.en_n), "write byte enables");
          for (b = 0; b < `WB2SDR_SEL_W; b++) begin
            if (!sdr_wr_en_n_o[b]) begin
              model_mem[sdr_req_addr_o[5:0]][8*b +: 8] = sdr_wr_data_o[8*b +: 8];
            end
          end
        end else begin
          rd_busy = 1'b1;
          rd_idx  = sdr_req_addr_o[5:0];
          take_bits(3, rd_wait);
        end
        take_bits(2, gap);
      end
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/wb2sdr_pkg.sv
hw/sync_fifo.sv
hw/wb_req_ctrl.sv
hw/wb2sdr_top.sv
tests/wb2sdr_assertions.sv
tests/tb_wb2sdr.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Wishbone to SDRAM bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f tb.f --top-module tb_wb2sdr -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# Verdict comes from the log
if grep -qx "test failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
